/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_read_tb
FILELIST  ?= dcache_read.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dcache_read.f */
+incdir+.
verilog/dcache_pkg.sv
verilog/dcache_req_buffer.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_bank.sv
verilog/mem_rd_ctrl_d.sv
verilog/dcache_read_top.sv
testbench/dcache_read_sva.sv
testbench/dcache_read_tb.sv

/* dcache_read_defines.svh */
`ifndef DCACHE_READ_DEFINES_SVH
`define DCACHE_READ_DEFINES_SVH

// cache geometry.
`define DC_WAYS       4
`define DC_SETS       64
`define DC_LINE_BITS  512

// read-type byte masks.
`define RT_BYTE       4'b0001
`define RT_HALF       4'b0011
`define RT_WORD       4'b1111

// cache operation codes.
`define CACOP_IDX_RD  2'b01
`define CACOP_HIT_RD  2'b10

`endif

/* testbench/dcache_read_sva.sv */
`timescale 1ns/1ps

module dcache_read_sva import dcache_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input dcache_req_t req,
    input logic        busy,
    input logic        miss,
    input logic        resp_valid,
    input line_t       miss_sel_data
);

    logic accepted;
    logic pending;
    int   fail_count = 0;

    assign accepted = req.valid && !busy;

    // set by an accepted request, cleared by its response.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (accepted) begin
            pending <= 1'b1;
        end else if (resp_valid) begin
            pending <= 1'b0;
        end
    end

    resp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> pending)
        else begin
            $error("response without an accepted request");
            fail_count++;
        end

    // a response outside the miss state is a lookup answer.
    hit_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && !miss) |-> $past(accepted))
        else begin
            $error("lookup response not one cycle after acceptance");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!miss && !busy && !resp_valid))
        else begin
            $error("miss, busy or resp_valid high after reset");
            fail_count++;
        end

    miss_line_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (miss && $past(miss)) |-> $stable(miss_sel_data))
        else begin
            $error("miss_sel_data changed while miss was high");
            fail_count++;
        end

endmodule

bind dcache_read_top dcache_read_sva u_dcache_read_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req),
    .busy          (busy),
    .miss          (miss),
    .resp_valid    (resp_valid),
    .miss_sel_data (miss_sel_data)
);

/* testbench/dcache_read_tb.sv */
`timescale 1ns/1ps
`include "dcache_read_defines.svh"

module dcache_read_tb import dcache_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_REQS     = 36;
    localparam int REQ_CYCLES   = 12;
    localparam int WAIT_LIMIT   = 20;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_REQS * REQ_CYCLES * 4) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    dcache_req_t req;
    logic        refill_valid;
    line_t       refill_data;
    logic        busy;
    logic        miss;
    addr_t       miss_addr;
    line_t       miss_sel_data;
    logic        resp_valid;
    word_t       r_data;

    // memory lines keyed by line address, shadow tags and valid bits.
    line_t      mem_model [addr_t];
    tag_t       tag_sh [`DC_SETS][`DC_WAYS];
    way_sel_t   valid_sh [`DC_SETS];
    logic [1:0] rr_sh;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;

    dcache_read_top u_dcache_read_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .refill_valid  (refill_valid),
        .refill_data   (refill_data),
        .busy          (busy),
        .miss          (miss),
        .miss_addr     (miss_addr),
        .miss_sel_data (miss_sel_data),
        .resp_valid    (resp_valid),
        .r_data        (r_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic line_t model_line(addr_t a);
        addr_t key;
        line_t l;
        key = {a[31:6], 6'b0};
        if (!mem_model.exists(key)) begin
            for (int i = 0; i < 16; i++) begin
                l[i*32 +: 32] = $urandom;
            end
            mem_model[key] = l;
        end
        return mem_model[key];
    endfunction

    function automatic word_t model_word(addr_t a);
        line_t l;
        l = model_line(a);
        return l[a[5:2]*32 +: 32];
    endfunction

    // expected load result from the byte mask and the extension.
    function automatic word_t load_value(word_t w, read_type_t rt, logic [1:0] off, logic sext);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = 16'(w >> (8 * off));
        if (rt == `RT_BYTE) begin
            return sext ? 32'($signed(b)) : 32'(b);
        end else if (rt == `RT_HALF && off[0] == 1'b0) begin
            return sext ? 32'($signed(h)) : 32'(h);
        end else if (rt == `RT_WORD) begin
            return w;
        end
        return '0;
    endfunction

    function automatic way_sel_t find_hit(addr_t a);
        way_sel_t h;
        index_t   idx;
        h = '0;
        idx = a[11:6];
        for (int w = 0; w < `DC_WAYS; w++) begin
            h[w] = valid_sh[idx][w] && (tag_sh[idx][w] == a[31:12]);
        end
        return h;
    endfunction

    function automatic logic [1:0] pick_victim(index_t idx);
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (!valid_sh[idx][w]) begin
                return 2'(w);
            end
        end
        return rr_sh;
    endfunction

    function automatic dcache_req_t make_req(addr_t a, read_type_t rt, logic sext,
                                             logic unc, logic op);
        dcache_req_t r;
        r = '0;
        r.valid = 1'b1;
        r.addr = a;
        r.read_type = rt;
        r.signed_ext = sext;
        r.uncache = unc;
        r.op = op;
        return r;
    endfunction

    task automatic check_word(string name, word_t exp, word_t got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_line(string name, line_t exp, line_t got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, got);
            errors++;
        end
    endtask

    // runs one request to its response and answers any refill from the model.
    task automatic access(input string name, input dcache_req_t r, output word_t data,
                          output logic missed, output line_t wb_line,
                          output addr_t maddr, output int lat);
        index_t     idx;
        logic [1:0] victim;
        way_sel_t   hit;
        line_t      fill;
        idx = r.addr[11:6];
        victim = pick_victim(idx);
        hit = find_hit(r.addr);
        fill = model_line(r.addr);
        if (r.uncache) begin
            fill[31:0] = model_word(r.addr);
        end
        data = '0;
        missed = 1'b0;
        wb_line = '0;
        maddr = '0;
        lat = 0;
        @(posedge clk);
        req <= r;
        @(negedge clk);
        check_word({name, " busy before accept"}, 0, 32'(busy));
        @(posedge clk);
        req.valid <= 1'b0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid && !miss && lat < WAIT_LIMIT);
        checks++;
        assert (resp_valid || miss) else begin
            $display("test %s: request got no response within %0d cycles", name, lat);
            errors++;
        end
        check_word({name, " busy after accept"}, 1, 32'(busy));
        if (miss) begin
            missed = 1'b1;
            maddr = miss_addr;
            wb_line = miss_sel_data;
            repeat ($urandom_range(3, 0)) @(posedge clk);
            @(posedge clk);
            refill_valid <= 1'b1;
            refill_data <= fill;
            @(negedge clk);
            checks++;
            assert (resp_valid) else begin
                $display("test %s: no response in the refill cycle", name);
                errors++;
            end
            check_word({name, " busy in refill"}, 1, 32'(busy));
            data = r_data;
            @(posedge clk);
            refill_valid <= 1'b0;
            if (!r.uncache && !r.cacop_en) begin
                tag_sh[idx][victim] = r.addr[31:12];
                valid_sh[idx][victim] = 1'b1;
                rr_sh++;
            end
        end else if (resp_valid) begin
            data = r_data;
            wb_line = miss_sel_data;
            if (r.cacop_en && r.cacop_code == `CACOP_IDX_RD) begin
                valid_sh[idx][r.addr[1:0]] = 1'b0;
            end else if (r.cacop_en && r.cacop_code == `CACOP_HIT_RD) begin
                valid_sh[idx] = valid_sh[idx] & ~hit;
            end
        end
    endtask

    task automatic report_test(string name, int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    task automatic test_cold_load();
        addr_t a;
        word_t d;
        logic  m;
        line_t wb;
        addr_t ma;
        int    lat;
        int    start;
        start = errors;
        a = 32'h0001_2144;
        access("cold_load", make_req(a, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        check_word("cold_load miss", 1, 32'(m));
        check_word("cold_load miss_addr", a, ma);
        check_word("cold_load r_data", model_word(a), d);
        access("cold_load", make_req(a, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        check_word("cold_load repeat miss", 0, 32'(m));
        check_word("cold_load repeat latency", 1, lat);
        check_word("cold_load repeat r_data", model_word(a), d);
        report_test("cold_load", start);
    endtask

    task automatic test_byte_half();
        addr_t      a;
        read_type_t rt;
        word_t      d;
        logic       m;
        line_t      wb;
        addr_t      ma;
        int         lat;
        int         start;
        start = errors;
        a = 32'h0003_4280;
        access("byte_half", make_req(a, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        for (int k = 0; k < 2; k++) begin
            rt = (k == 0) ? `RT_BYTE : `RT_HALF;
            for (int off = 0; off < 4; off++) begin
                for (int s = 0; s < 2; s++) begin
                    a = 32'h0003_4288 + off;
                    access("byte_half", make_req(a, rt, 1'(s), 1'b0, 1'b0), d, m, wb, ma, lat);
                    check_word("byte_half miss", 0, 32'(m));
                    check_word("byte_half r_data",
                               load_value(model_word(a), rt, a[1:0], 1'(s)), d);
                end
            end
        end
        report_test("byte_half", start);
    endtask

    task automatic test_eviction();
        addr_t      a;
        logic [1:0] victim;
        line_t      exp_line;
        word_t      d;
        logic       m;
        line_t      wb;
        addr_t      ma;
        int         lat;
        int         start;
        start = errors;
        exp_line = '0;
        for (int i = 0; i < 5; i++) begin
            a = {20'h00100 + 20'(i), 6'd20, 6'h0};
            // the fifth tag finds the set full.
            if (i == 4) begin
                victim = pick_victim(6'd20);
                exp_line = model_line({tag_sh[20][victim], 6'd20, 6'h0});
            end
            access("eviction", make_req(a, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
            check_word("eviction miss", 1, 32'(m));
            if (i == 4) begin
                check_line("eviction victim line", exp_line, wb);
            end
        end
        report_test("eviction", start);
    endtask

    task automatic test_uncached();
        dcache_req_t r;
        addr_t       a;
        word_t       d;
        logic        m;
        line_t       wb;
        addr_t       ma;
        int          lat;
        int          start;
        start = errors;
        a = 32'h0005_6304;
        access("uncached", make_req(a, `RT_WORD, 1'b0, 1'b1, 1'b0), d, m, wb, ma, lat);
        check_word("uncached load miss", 1, 32'(m));
        check_word("uncached load r_data", model_word(a), d);
        access("uncached", make_req(a, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        check_word("uncached no allocate", 1, 32'(m));
        r = make_req(32'h0005_6380, `RT_WORD, 1'b0, 1'b1, 1'b1);
        r.w_data = $urandom;
        access("uncached", r, d, m, wb, ma, lat);
        check_line("uncached store line", {{(`DC_LINE_BITS - 32){1'b0}}, r.w_data}, wb);
        report_test("uncached", start);
    endtask

    task automatic test_sc();
        dcache_req_t r;
        word_t       d;
        logic        m;
        line_t       wb;
        addr_t       ma;
        int          lat;
        int          start;
        start = errors;
        for (int u = 0; u < 2; u++) begin
            for (int ll = 0; ll < 2; ll++) begin
                r = make_req(32'h0009_0A00, `RT_WORD, 1'b0, 1'(u), 1'b1);
                r.is_atom = 1'b1;
                r.llbit = 1'(ll);
                access("sc", r, d, m, wb, ma, lat);
                check_word("sc path", u, 32'(m));
                check_word("sc r_data", ll, d);
            end
        end
        report_test("sc", start);
    endtask

    task automatic test_cacop();
        dcache_req_t r;
        addr_t       line;
        word_t       d;
        logic        m;
        line_t       wb;
        addr_t       ma;
        int          lat;
        int          start;
        start = errors;
        line = {tag_sh[20][2], 6'd20, 6'h0};
        // the tag matches way 1 while the low bits name way 2.
        r = make_req({tag_sh[20][1], 6'd20, 6'h0} | 32'd2, `RT_WORD, 1'b0, 1'b0, 1'b0);
        r.cacop_en = 1'b1;
        r.cacop_code = `CACOP_IDX_RD;
        access("cacop", r, d, m, wb, ma, lat);
        check_line("cacop index-read line", model_line(line), wb);
        access("cacop", make_req(line, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        check_word("cacop index-read invalidate", 1, 32'(m));
        line = 32'h0007_8780;
        access("cacop", make_req(line, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        r = make_req(line, `RT_WORD, 1'b0, 1'b0, 1'b0);
        r.cacop_en = 1'b1;
        r.cacop_code = `CACOP_HIT_RD;
        access("cacop", r, d, m, wb, ma, lat);
        check_line("cacop hit-read line", model_line(line), wb);
        access("cacop", make_req(line, `RT_WORD, 1'b0, 1'b0, 1'b0), d, m, wb, ma, lat);
        check_word("cacop hit-read invalidate", 1, 32'(m));
        report_test("cacop", start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(24687));
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        refill_valid = 1'b0;
        refill_data = '0;
        rr_sh = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int s = 0; s < `DC_SETS; s++) begin
            valid_sh[s] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_cold_load();
        test_byte_half();
        test_eviction();
        test_uncached();
        test_sc();
        test_cacop();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d, sva failures %0d",
                 tests_run, tests_failed, checks, errors,
                 u_dcache_read_top.u_dcache_read_sva.fail_count);
        if (errors == 0 && u_dcache_read_top.u_dcache_read_sva.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/dcache_data_bank.sv */
`timescale 1ns/1ps
`include "dcache_read_defines.svh"

module dcache_data_bank import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rd_en,
    input  addr_t      rd_addr,
    input  logic       we,
    input  addr_t      wr_addr,
    input  way_sel_t   wr_way,
    input  line_t      wr_line,
    output set_lines_t mem_dout
);

    line_t  mem [`DC_WAYS][`DC_SETS];
    index_t rd_idx;
    index_t wr_idx;

    assign rd_idx = rd_addr[11:6];
    assign wr_idx = wr_addr[11:6];

    // way w sits at bits w*512 upward in mem_dout.
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (rd_en) begin
                mem_dout[w*`DC_LINE_BITS +: `DC_LINE_BITS] <= mem[w][rd_idx];
            end
        end
    end

    // whole-line write into the one selected way.
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (we && wr_way[w]) begin
                mem[w][wr_idx] <= wr_line;
            end
        end
    end

endmodule

/* verilog/dcache_pkg.sv */
`include "dcache_read_defines.svh"

package dcache_pkg;

    typedef logic [31:0]                          addr_t;
    typedef logic [31:0]                          word_t;
    typedef logic [`DC_LINE_BITS-1:0]             line_t;
    typedef logic [`DC_WAYS*`DC_LINE_BITS-1:0]    set_lines_t;
    typedef logic [`DC_WAYS-1:0]                  way_sel_t;
    typedef logic [19:0]                          tag_t;
    typedef logic [5:0]                           index_t;
    typedef logic [3:0]                           read_type_t;
    typedef logic [1:0]                           cacop_code_t;

    // op is 0 for load or LL, 1 for store or SC.
    typedef struct packed {
        logic        valid;
        logic        op;
        logic        is_atom;
        logic        uncache;
        read_type_t  read_type;
        logic        signed_ext;
        logic        cacop_en;
        cacop_code_t cacop_code;
        addr_t       addr;
        word_t       w_data;
        logic        llbit;
    } dcache_req_t;

    typedef enum logic [1:0] {
        RB_IDLE,
        RB_LOOKUP,
        RB_MISS
    } rbuf_state_t;

endpackage

/* verilog/dcache_read_top.sv */
`timescale 1ns/1ps

module dcache_read_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  dcache_req_t req,
    input  logic        refill_valid,
    input  line_t       refill_data,
    output logic        busy,
    output logic        miss,
    output addr_t       miss_addr,
    output line_t       miss_sel_data,
    output logic        resp_valid,
    output word_t       r_data
);

    dcache_req_t rbuf;
    way_sel_t    hit_way;
    way_sel_t    victim_way;
    way_sel_t    inval_way;
    set_lines_t  mem_dout;
    logic        rd_en;
    logic        lookup;
    logic        refill_we;
    logic        inval_en;
    logic        r_data_sel;

    dcache_req_buffer u_req_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .hit_way      (hit_way),
        .refill_valid (refill_valid),
        .rbuf         (rbuf),
        .rd_en        (rd_en),
        .lookup       (lookup),
        .refill_we    (refill_we),
        .inval_en     (inval_en),
        .inval_way    (inval_way),
        .busy         (busy),
        .miss         (miss),
        .miss_addr    (miss_addr),
        .resp_valid   (resp_valid),
        .r_data_sel   (r_data_sel)
    );

    dcache_tag_store u_tag_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .rd_addr    (req.addr),
        .rbuf_addr  (rbuf.addr),
        .lookup     (lookup),
        .refill_we  (refill_we),
        .inval_en   (inval_en),
        .inval_way  (inval_way),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    dcache_data_bank u_data_bank (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_addr  (req.addr),
        .we       (refill_we),
        .wr_addr  (rbuf.addr),
        .wr_way   (victim_way),
        .wr_line  (refill_data),
        .mem_dout (mem_dout)
    );

    mem_rd_ctrl_d u_mem_rd_ctrl_d (
        .addr_rbuf       (rbuf.addr),
        .w_data_CPU      (rbuf.w_data),
        .r_way_sel       (hit_way),
        .mem_dout        (mem_dout),
        .r_data_AXI      (refill_data),
        .r_data_sel      (r_data_sel),
        .read_type_rbuf  (rbuf.read_type),
        .uncache_rbuf    (rbuf.uncache),
        .signed_ext      (rbuf.signed_ext),
        .miss_way_sel    (victim_way),
        .cacop_en_rbuf   (rbuf.cacop_en),
        .cacop_code_rbuf (rbuf.cacop_code),
        .llbit_rbuf      (rbuf.llbit),
        .is_atom_rbuf    (rbuf.is_atom),
        .op_rbuf         (rbuf.op),
        .miss_sel_data   (miss_sel_data),
        .r_data          (r_data)
    );

endmodule

/* verilog/dcache_req_buffer.sv */
`timescale 1ns/1ps
`include "dcache_read_defines.svh"

module dcache_req_buffer import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  dcache_req_t req,
    input  way_sel_t    hit_way,
    input  logic        refill_valid,
    output dcache_req_t rbuf,
    output logic        rd_en,
    output logic        lookup,
    output logic        refill_we,
    output logic        inval_en,
    output way_sel_t    inval_way,
    output logic        busy,
    output logic        miss,
    output addr_t       miss_addr,
    output logic        resp_valid,
    output logic        r_data_sel
);

    rbuf_state_t state;
    rbuf_state_t state_next;
    logic        accept;
    logic        is_hit;
    logic        is_sc;
    logic        lookup_done;

    assign accept = (state == RB_IDLE) && req.valid;
    assign is_hit = |hit_way;
    assign is_sc  = rbuf.is_atom && rbuf.op;

    // a lookup answers at once unless the access has to go to the bus.
    assign lookup_done = rbuf.cacop_en || (!rbuf.uncache && (is_hit || is_sc));

    assign rd_en      = accept;
    assign lookup     = (state == RB_LOOKUP);
    assign busy       = (state != RB_IDLE);
    assign miss       = (state == RB_MISS);
    assign miss_addr  = rbuf.addr;
    assign r_data_sel = lookup;
    assign resp_valid = (lookup && lookup_done) || (miss && refill_valid);
    assign refill_we  = miss && refill_valid && !rbuf.uncache;
    assign inval_en   = lookup && rbuf.cacop_en;

    // index-read names the way in the low address bits.
    assign inval_way = (rbuf.cacop_code == `CACOP_IDX_RD) ?
                       way_sel_t'(1) << rbuf.addr[1:0] : hit_way;

    always_comb begin
        state_next = state;
        case (state)
            RB_IDLE: begin
                if (accept) begin
                    state_next = RB_LOOKUP;
                end
            end
            RB_LOOKUP: begin
                state_next = lookup_done ? RB_IDLE : RB_MISS;
            end
            RB_MISS: begin
                if (refill_valid) begin
                    state_next = RB_IDLE;
                end
            end
            default: state_next = RB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf <= req;
        end
    end

endmodule

/* verilog/dcache_tag_store.sv */
`timescale 1ns/1ps
`include "dcache_read_defines.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rd_en,
    input  addr_t    rd_addr,
    input  addr_t    rbuf_addr,
    input  logic     lookup,
    input  logic     refill_we,
    input  logic     inval_en,
    input  way_sel_t inval_way,
    output way_sel_t hit_way,
    output way_sel_t victim_way
);

    tag_t     tag_arr [`DC_SETS][`DC_WAYS];
    way_sel_t valid_arr [`DC_SETS];
    tag_t     tag_q [`DC_WAYS];
    way_sel_t valid_q;
    way_sel_t victim_next;
    way_sel_t victim_q;
    logic [1:0] rr_cnt;
    index_t   rd_idx;
    index_t   rb_idx;
    tag_t     rb_tag;

    assign rd_idx = rd_addr[11:6];
    assign rb_idx = rbuf_addr[11:6];
    assign rb_tag = rbuf_addr[31:12];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                tag_q[w] <= tag_arr[rd_idx][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (rd_en) begin
            valid_q <= valid_arr[rd_idx];
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = valid_q[w] && (tag_q[w] == rb_tag);
        end
    end

    // lowest invalid way wins, a full set falls back to the counter.
    always_comb begin
        victim_next = way_sel_t'(1) << rr_cnt;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w]) begin
                victim_next = way_sel_t'(1) << w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim_q <= '0;
            rr_cnt   <= '0;
        end else begin
            if (lookup) begin
                victim_q <= victim_next;
            end
            // counter steps on every cached refill.
            if (refill_we) begin
                rr_cnt <= rr_cnt + 2'd1;
            end
        end
    end

    assign victim_way = victim_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_arr[s] <= '0;
            end
        end else if (refill_we) begin
            valid_arr[rb_idx] <= valid_arr[rb_idx] | victim_q;
        end else if (inval_en) begin
            valid_arr[rb_idx] <= valid_arr[rb_idx] & ~inval_way;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (refill_we && victim_q[w]) begin
                tag_arr[rb_idx][w] <= rb_tag;
            end
        end
    end

endmodule

/* verilog/mem_rd_ctrl_d.sv */
`timescale 1ns/1ps
`include "dcache_read_defines.svh"

module mem_rd_ctrl_d import dcache_pkg::*; (
    input  addr_t       addr_rbuf,
    input  word_t       w_data_CPU,
    input  way_sel_t    r_way_sel,
    input  set_lines_t  mem_dout,
    input  line_t       r_data_AXI,
    input  logic        r_data_sel,
    input  read_type_t  read_type_rbuf,
    input  logic        uncache_rbuf,
    input  logic        signed_ext,
    input  way_sel_t    miss_way_sel,
    input  logic        cacop_en_rbuf,
    input  cacop_code_t cacop_code_rbuf,
    input  logic        llbit_rbuf,
    input  logic        is_atom_rbuf,
    input  logic        op_rbuf,
    output line_t       miss_sel_data,
    output word_t       r_data
);

    line_t       way_data;
    line_t       victim_data;
    word_t       r_data_mem;
    word_t       r_word_AXI;
    word_t       r_data_CPU;
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic [3:0]  word_off;
    logic [1:0]  byte_off;

    assign word_off = addr_rbuf[5:2];
    assign byte_off = addr_rbuf[1:0];

    // hit way and victim way are both one-hot.
    always_comb begin
        way_data    = '0;
        victim_data = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (r_way_sel[w]) begin
                way_data = mem_dout[w*`DC_LINE_BITS +: `DC_LINE_BITS];
            end
            if (miss_way_sel[w]) begin
                victim_data = mem_dout[w*`DC_LINE_BITS +: `DC_LINE_BITS];
            end
        end
    end

    assign r_data_mem = way_data[word_off*32 +: 32];

    // uncached refill carries its word at bit 0.
    assign r_word_AXI = uncache_rbuf ? r_data_AXI[31:0] : r_data_AXI[word_off*32 +: 32];

    assign r_data_CPU = r_data_sel ? r_data_mem : r_word_AXI;

    assign byte_val = r_data_CPU[byte_off*8 +: 8];
    assign half_val = r_data_CPU[byte_off[1]*16 +: 16];

    always_comb begin
        r_data = '0;
        if (is_atom_rbuf && op_rbuf) begin
            r_data = {31'b0, llbit_rbuf};
        end else begin
            case (read_type_rbuf)
                `RT_BYTE: begin
                    r_data = {{24{byte_val[7] & signed_ext}}, byte_val};
                end
                `RT_HALF: begin
                    // odd half offsets are misaligned.
                    if (!byte_off[0]) begin
                        r_data = {{16{half_val[15] & signed_ext}}, half_val};
                    end
                end
                `RT_WORD: r_data = r_data_CPU;
                default:  r_data = '0;
            endcase
        end
    end

    // writeback line for cache ops, else store word or victim line.
    always_comb begin
        if (cacop_en_rbuf && cacop_code_rbuf == `CACOP_IDX_RD) begin
            miss_sel_data = mem_dout[byte_off*`DC_LINE_BITS +: `DC_LINE_BITS];
        end else if (cacop_en_rbuf && cacop_code_rbuf == `CACOP_HIT_RD) begin
            miss_sel_data = way_data;
        end else if (uncache_rbuf) begin
            miss_sel_data = line_t'(w_data_CPU);
        end else begin
            miss_sel_data = victim_data;
        end
    end

endmodule
